// ==== wrot_cfg.svh ====
// Weight rotator configuration macros for core count, word sizes and bank sizing
`ifndef WROT_CFG_SVH
`define WROT_CFG_SVH

`define WROT_CORES          2
`define WROT_WORD_W         8

// Kernel sizes are odd
`define WROT_KW_MAX         3
`define WROT_KH_MAX         3

`define WROT_CIN_MAX        16
`define WROT_COLS_MAX       8
`define WROT_BLOCKS_MAX     8

// Activation config words that precede the weights
`define WROT_CFG_BEATS_3X3  21
`define WROT_CFG_BEATS_1X1  13

// One bank word feeds every core with one full kernel row
`define WROT_BANK_W         (`WROT_CORES * `WROT_WORD_W * `WROT_KW_MAX)

// Room for the largest weight set plus the longer config block
`define WROT_BANK_DEPTH     (`WROT_KH_MAX * `WROT_CIN_MAX + `WROT_CFG_BEATS_3X3)

`endif

// ==== wrot_pkg.sv ====
// Weight rotator types for the header, bank references, write beats, read stream and tag
`default_nettype none

`include "wrot_cfg.svh"

package wrot_pkg;

  localparam int KW_W     = $clog2(`WROT_KW_MAX);
  localparam int KH_W     = $clog2(`WROT_KH_MAX);
  localparam int CIN_W    = $clog2(`WROT_CIN_MAX);
  localparam int COLS_W   = $clog2(`WROT_COLS_MAX);
  localparam int BLOCKS_W = $clog2(`WROT_BLOCKS_MAX);
  localparam int ADDR_W   = $clog2(`WROT_BANK_DEPTH);

  typedef logic [ADDR_W-1:0] addr_t;

  // Sits in the low bits of the first DMA beat, kw_1 at bit 0
  typedef struct packed {
    logic [BLOCKS_W-1:0] blocks_1;
    logic [COLS_W-1:0]   cols_1;
    logic [CIN_W-1:0]    cin_1;
    logic [KH_W-1:0]     kh_1;
    logic [KW_W-1:0]     kw_1;
  } hdr_t;

  typedef struct packed {
    hdr_t  hdr;
    addr_t addr_min;   // Number of config words, first weight address
    addr_t addr_max;   // Address of the final weight word
  } ref_t;

  typedef struct packed {
    logic [`WROT_BANK_W-1:0] data;
    logic                    last;
  } wr_beat_t;

  typedef struct packed {
    logic [`WROT_BANK_W-1:0] data;
  } stream_t;

  // Side-band word for the conv engine, is_top_block is bit 0
  typedef struct packed {
    logic [KW_W-1:0] kw_1;
    logic            is_acc_last;
    logic            is_config;
    logic            is_cols_1_k2;
    logic            is_1x1;
    logic            is_bottom_block;
    logic            is_top_block;
  } tag_t;

endpackage

`default_nettype wire

// ==== wrot_header_decode.sv ====
// Weight rotator decode stage that splits each DMA set into a header and bank write beats
`timescale 1ns/10ps
`default_nettype none

`include "wrot_cfg.svh"

module wrot_header_decode (
  input  wire                      i_aclk,
  input  wire                      i_arst_n,
  input  wire                      i_s_valid,
  output logic                     o_s_ready,
  input  wire  [`WROT_BANK_W-1:0]  i_s_data,
  input  wire                      i_s_last,
  input  wire                      i_hdr_ready,
  input  wire                      i_wr_ready,
  output logic                     o_hdr_fire,
  output wrot_pkg::ref_t           o_ref,
  output logic                     o_wr_valid,
  output wrot_pkg::wr_beat_t       o_wr
);

  logic            in_body;   // Low while the next beat is a header
  logic            s_fire;
  wrot_pkg::hdr_t  hdr;
  wrot_pkg::addr_t cfg_beats;

  // Header beats go to the reference registers, the rest go into a bank
  assign o_s_ready  = in_body ? i_wr_ready : i_hdr_ready;
  assign s_fire     = i_s_valid && o_s_ready;
  assign o_hdr_fire = s_fire && !in_body;

  assign o_wr_valid = i_s_valid && in_body;
  assign o_wr.data  = i_s_data;
  assign o_wr.last  = i_s_last;

  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      in_body <= 1'b0;
    end else if (o_hdr_fire) begin
      in_body <= 1'b1;
    end else if (s_fire && i_s_last) begin
      in_body <= 1'b0;   // Set complete, expect the next header
    end
  end

  assign hdr = wrot_pkg::hdr_t'(i_s_data[$bits(wrot_pkg::hdr_t)-1:0]);

  // A kernel of height one carries the shorter config block
  assign cfg_beats = (hdr.kh_1 == '0) ? wrot_pkg::addr_t'(`WROT_CFG_BEATS_1X1)
                                      : wrot_pkg::addr_t'(`WROT_CFG_BEATS_3X3);

  assign o_ref.hdr      = hdr;
  assign o_ref.addr_min = cfg_beats;

  // The weight count minus one is kh*cin + kh + cin, all in minus-one form
  assign o_ref.addr_max = wrot_pkg::addr_t'(hdr.kh_1) * wrot_pkg::addr_t'(hdr.cin_1)
                        + wrot_pkg::addr_t'(hdr.kh_1)
                        + wrot_pkg::addr_t'(hdr.cin_1)
                        + cfg_beats;

endmodule

`default_nettype wire

// ==== wrot_bank.sv ====
// Weight bank with a linear write side and a cyclic registered read side
`timescale 1ns/10ps
`default_nettype none

`include "wrot_cfg.svh"

module wrot_bank (
  input  wire                      i_aclk,
  input  wire                      i_arst_n,
  input  wire                      i_clear,
  input  wire                      i_wen,
  input  wire  [`WROT_BANK_W-1:0]  i_wdata,
  input  wire  wrot_pkg::addr_t    i_addr_min,
  input  wire  wrot_pkg::addr_t    i_addr_max,
  output logic                     o_valid,
  output wrot_pkg::stream_t        o_data,
  input  wire                      i_ready
);

  logic [`WROT_BANK_W-1:0] mem [`WROT_BANK_DEPTH];

  wrot_pkg::addr_t wptr;
  wrot_pkg::addr_t raddr;
  logic            full;   // Whole set is in, reading may start
  logic            load;

  // Fetch into the output register when it is empty or being accepted
  assign load = full && (!o_valid || i_ready);

  always_ff @(posedge i_aclk) begin
    if (i_wen) begin
      mem[wptr] <= i_wdata;
    end
  end

  always_ff @(posedge i_aclk) begin
    if (load) begin
      o_data.data <= mem[raddr];
    end
  end

  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wptr    <= '0;
      raddr   <= '0;
      full    <= 1'b0;
      o_valid <= 1'b0;
    end else if (i_clear) begin
      wptr    <= '0;
      raddr   <= '0;
      full    <= 1'b0;
      o_valid <= 1'b0;
    end else begin
      if (i_wen) begin
        wptr <= wptr + 1'b1;
        if (wptr == i_addr_max) begin
          full <= 1'b1;
        end
      end
      if (load) begin
        o_valid <= 1'b1;
        // Wrap past the config words so only the weights repeat
        raddr   <= (raddr == i_addr_max) ? i_addr_min : raddr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== wrot_bank_exec.sv ====
// Weight rotator execute stage that ping-pongs writes and reads over two banks
`timescale 1ns/10ps
`default_nettype none

module wrot_bank_exec (
  input  wire                 i_aclk,
  input  wire                 i_arst_n,
  input  wire                 i_hdr_fire,
  input  wire  wrot_pkg::ref_t     i_ref,
  output logic                o_hdr_ready,
  input  wire                 i_wr_valid,
  input  wire  wrot_pkg::wr_beat_t i_wr,
  output logic                o_wr_ready,
  output logic                o_rd_valid,
  output wrot_pkg::stream_t   o_rd,
  output wrot_pkg::ref_t      o_rd_ref,
  input  wire                 i_rd_ready,
  input  wire                 i_read_done
);

  typedef enum logic [1:0] {W_IDLE, W_GET_HDR, W_WRITE, W_SWITCH} wr_state_e;
  typedef enum logic [1:0] {R_IDLE, R_READ, R_SWITCH} rd_state_e;

  wr_state_e wr_state;
  rd_state_e rd_state;

  logic wr_idx;   // Bank being filled
  logic rd_idx;   // Bank being replayed

  logic [1:0] done_write;   // Bank holds a complete set
  logic [1:0] done_read;    // Bank is free for a new set
  logic [1:0] bank_valid;

  wrot_pkg::ref_t    ref_q     [2];
  wrot_pkg::stream_t bank_data [2];

  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_state <= W_IDLE;
      wr_idx   <= 1'b0;
    end else begin
      case (wr_state)
        W_IDLE:    if (done_read[wr_idx]) wr_state <= W_GET_HDR;
        W_GET_HDR: if (i_hdr_fire) wr_state <= W_WRITE;
        W_WRITE:   if (i_wr_valid && i_wr.last) wr_state <= W_SWITCH;
        W_SWITCH: begin
          wr_state <= W_IDLE;
          wr_idx   <= !wr_idx;
        end
        default:   wr_state <= W_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rd_state <= R_IDLE;
      rd_idx   <= 1'b0;
    end else begin
      case (rd_state)
        R_IDLE:   if (done_write[rd_idx]) rd_state <= R_READ;
        R_READ:   if (i_read_done) rd_state <= R_SWITCH;
        R_SWITCH: begin
          rd_state <= R_IDLE;
          rd_idx   <= !rd_idx;
        end
        default:  rd_state <= R_IDLE;
      endcase
    end
  end

  assign o_hdr_ready = (wr_state == W_GET_HDR);
  assign o_wr_ready  = (wr_state == W_WRITE);

  for (genvar b = 0; b < 2; b++) begin : g_bank
    logic wr_sel;
    logic rd_sel;

    assign wr_sel = (wr_idx == 1'(b));
    assign rd_sel = (rd_idx == 1'(b));

    // The two flags keep the write and read machines on different banks
    always_ff @(posedge i_aclk or negedge i_arst_n) begin
      if (!i_arst_n) begin
        done_write[b] <= 1'b0;
        done_read[b]  <= 1'b1;
        ref_q[b]      <= '0;
      end else begin
        if (wr_sel && wr_state == W_GET_HDR) begin
          done_write[b] <= 1'b0;
        end else if (wr_sel && wr_state == W_SWITCH) begin
          done_write[b] <= 1'b1;
        end
        if (rd_sel && rd_state == R_IDLE && done_write[b]) begin
          done_read[b] <= 1'b0;
        end else if (rd_sel && rd_state == R_SWITCH) begin
          done_read[b] <= 1'b1;
        end
        if (wr_sel && i_hdr_fire) begin
          ref_q[b] <= i_ref;
        end
      end
    end

    wrot_bank u_bank (
      .i_aclk     (i_aclk),
      .i_arst_n   (i_arst_n),
      .i_clear    (wr_sel && wr_state == W_GET_HDR),
      .i_wen      (wr_sel && wr_state == W_WRITE && i_wr_valid),
      .i_wdata    (i_wr.data),
      .i_addr_min (ref_q[b].addr_min),
      .i_addr_max (ref_q[b].addr_max),
      .o_valid    (bank_valid[b]),
      .o_data     (bank_data[b]),
      .i_ready    (rd_sel && rd_state == R_READ && i_rd_ready)
    );
  end

  assign o_rd_valid = (rd_state == R_READ) && bank_valid[rd_idx];
  assign o_rd       = bank_data[rd_idx];
  assign o_rd_ref   = ref_q[rd_idx];

endmodule

`default_nettype wire

// ==== wrot_tag_gen.sv ====
// Weight rotator result stage that counts the replay and builds the tag and last flag
`timescale 1ns/10ps
`default_nettype none

`include "wrot_cfg.svh"

module wrot_tag_gen (
  input  wire                      i_aclk,
  input  wire                      i_arst_n,
  input  wire                      i_rd_valid,
  input  wire  wrot_pkg::stream_t  i_rd,
  input  wire  wrot_pkg::ref_t     i_rd_ref,
  output logic                     o_rd_ready,
  output logic                     o_read_done,
  output logic                     o_m_valid,
  input  wire                      i_m_ready,
  output logic [`WROT_BANK_W-1:0]  o_m_data,
  output logic                     o_m_last,
  output wrot_pkg::tag_t           o_m_user
);

  logic                          fire;
  logic                          in_cfg;   // Config words are still going out
  logic                          last_cfg;
  logic                          load;     // Start of the weights, counters take the refs
  wrot_pkg::addr_t               cnt_cfg;
  logic [wrot_pkg::KH_W-1:0]     cnt_kh;
  logic [wrot_pkg::CIN_W-1:0]    cnt_cin;
  logic [wrot_pkg::COLS_W-1:0]   cnt_cols;
  logic [wrot_pkg::BLOCKS_W-1:0] cnt_blocks;
  logic last_kh, last_cin, last_cols, last_blocks;
  logic en_kh, en_cin, en_cols, en_blocks;

  assign o_rd_ready = i_m_ready;
  assign o_m_valid  = i_rd_valid;
  assign o_m_data   = i_rd.data;
  assign fire       = i_rd_valid && i_m_ready;

  assign last_cfg = (cnt_cfg == i_rd_ref.addr_min - 1'b1);
  assign load     = fire && in_cfg && last_cfg;

  // Nested order is kh, then cin, then cols, then blocks
  assign en_kh     = load || (fire && !in_cfg);
  assign en_cin    = load || (fire && !in_cfg && last_kh);
  assign en_cols   = load || (fire && !in_cfg && last_kh && last_cin);
  assign en_blocks = load || (fire && !in_cfg && last_kh && last_cin && last_cols);

  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      in_cfg     <= 1'b1;
      cnt_cfg    <= '0;
      cnt_kh     <= '0;
      cnt_cin    <= '0;
      cnt_cols   <= '0;
      cnt_blocks <= '0;
      {last_kh, last_cin, last_cols, last_blocks} <= '0;
    end else begin
      if (load) begin
        in_cfg  <= 1'b0;
        cnt_cfg <= '0;
      end else if (fire && in_cfg) begin
        cnt_cfg <= cnt_cfg + 1'b1;
      end else if (o_read_done) begin
        in_cfg  <= 1'b1;   // Next set starts with its config words
      end
      // Each counter reloads from its ref after reaching zero
      if (en_kh) begin
        cnt_kh  <= (load || last_kh) ? i_rd_ref.hdr.kh_1 : cnt_kh - 1'b1;
        last_kh <= (load || last_kh) ? (i_rd_ref.hdr.kh_1 == '0) : (cnt_kh == 1);
      end
      if (en_cin) begin
        cnt_cin  <= (load || last_cin) ? i_rd_ref.hdr.cin_1 : cnt_cin - 1'b1;
        last_cin <= (load || last_cin) ? (i_rd_ref.hdr.cin_1 == '0) : (cnt_cin == 1);
      end
      if (en_cols) begin
        cnt_cols  <= (load || last_cols) ? i_rd_ref.hdr.cols_1 : cnt_cols - 1'b1;
        last_cols <= (load || last_cols) ? (i_rd_ref.hdr.cols_1 == '0) : (cnt_cols == 1);
      end
      if (en_blocks) begin
        cnt_blocks  <= (load || last_blocks) ? i_rd_ref.hdr.blocks_1 : cnt_blocks - 1'b1;
        last_blocks <= (load || last_blocks) ? (i_rd_ref.hdr.blocks_1 == '0)
                                             : (cnt_blocks == 1);
      end
    end
  end

  assign o_m_last    = !in_cfg && last_kh && last_cin && last_cols && last_blocks;
  assign o_read_done = fire && o_m_last;

  assign o_m_user.kw_1            = i_rd_ref.hdr.kw_1;
  assign o_m_user.is_1x1          = (i_rd_ref.hdr.kw_1 == '0);
  assign o_m_user.is_config       = in_cfg;
  assign o_m_user.is_acc_last     = !in_cfg && last_kh && last_cin;
  assign o_m_user.is_top_block    = !in_cfg && (cnt_blocks == i_rd_ref.hdr.blocks_1);
  assign o_m_user.is_bottom_block = !in_cfg && last_blocks;
  // Remaining columns equal half the kernel width
  assign o_m_user.is_cols_1_k2    = !in_cfg
                                  && (cnt_cols == wrot_pkg::COLS_W'(i_rd_ref.hdr.kw_1 >> 1));

endmodule

`default_nettype wire

// ==== axis_weight_rotator.sv ====
// Weight rotator top level joining the decode, bank execute and tag stages
`timescale 1ns/10ps
`default_nettype none

`include "wrot_cfg.svh"

module axis_weight_rotator (
  input  wire                      i_aclk,
  input  wire                      i_arst_n,
  input  wire                      i_s_valid,
  output logic                     o_s_ready,
  input  wire  [`WROT_BANK_W-1:0]  i_s_data,
  input  wire                      i_s_last,
  output logic                     o_m_valid,
  input  wire                      i_m_ready,
  output logic [`WROT_BANK_W-1:0]  o_m_data,
  output logic                     o_m_last,
  output wrot_pkg::tag_t           o_m_user
);

  logic               hdr_fire, hdr_ready;
  logic               wr_valid, wr_ready;
  logic               rd_valid, rd_ready, read_done;
  wrot_pkg::ref_t     hdr_ref;
  wrot_pkg::ref_t     rd_ref;
  wrot_pkg::wr_beat_t wr_beat;
  wrot_pkg::stream_t  rd_beat;

  wrot_header_decode u_decode (
    .i_aclk      (i_aclk),
    .i_arst_n    (i_arst_n),
    .i_s_valid   (i_s_valid),
    .o_s_ready   (o_s_ready),
    .i_s_data    (i_s_data),
    .i_s_last    (i_s_last),
    .i_hdr_ready (hdr_ready),
    .i_wr_ready  (wr_ready),
    .o_hdr_fire  (hdr_fire),
    .o_ref       (hdr_ref),
    .o_wr_valid  (wr_valid),
    .o_wr        (wr_beat)
  );

  wrot_bank_exec u_exec (
    .i_aclk      (i_aclk),
    .i_arst_n    (i_arst_n),
    .i_hdr_fire  (hdr_fire),
    .i_ref       (hdr_ref),
    .o_hdr_ready (hdr_ready),
    .i_wr_valid  (wr_valid),
    .i_wr        (wr_beat),
    .o_wr_ready  (wr_ready),
    .o_rd_valid  (rd_valid),
    .o_rd        (rd_beat),
    .o_rd_ref    (rd_ref),
    .i_rd_ready  (rd_ready),
    .i_read_done (read_done)
  );

  wrot_tag_gen u_tag (
    .i_aclk      (i_aclk),
    .i_arst_n    (i_arst_n),
    .i_rd_valid  (rd_valid),
    .i_rd        (rd_beat),
    .i_rd_ref    (rd_ref),
    .o_rd_ready  (rd_ready),
    .o_read_done (read_done),
    .o_m_valid   (o_m_valid),
    .i_m_ready   (i_m_ready),
    .o_m_data    (o_m_data),
    .o_m_last    (o_m_last),
    .o_m_user    (o_m_user)
  );

endmodule

`default_nettype wire

// ==== tb_wrot_chk.sv ====
// Weight rotator output checker with concurrent assertions on the master stream handshake
`timescale 1ns/10ps
`default_nettype none

`include "wrot_cfg.svh"

module tb_wrot_chk (
  input wire                      i_aclk,
  input wire                      i_arst_n,
  input wire                      i_m_valid,
  input wire                      i_m_ready,
  input wire  [`WROT_BANK_W-1:0]  i_m_data,
  input wire                      i_m_last,
  input wire  wrot_pkg::tag_t     i_m_user
);

  // A stalled beat stays on the bus unchanged until it is taken
  a_hold_stable : assert property (
    @(posedge i_aclk) disable iff (!i_arst_n)
    (i_m_valid && !i_m_ready) |=> (i_m_valid && $stable(i_m_data) && $stable(i_m_last)
                                   && $stable(i_m_user))
  ) else $error("Output beat changed while stalled by back-pressure");

  a_idle_in_reset : assert property (
    @(posedge i_aclk) !i_arst_n |-> !i_m_valid
  ) else $error("Output valid is high during reset");

endmodule

`default_nettype wire

// ==== tb_wrot.sv ====
// Weight rotator testbench that sends weight sets and checks the replayed stream and tags
`timescale 1ns/10ps
`default_nettype none

`include "wrot_cfg.svh"

module tb_wrot;

  localparam int CLK_PERIOD = 8;
  localparam int BW         = `WROT_BANK_W;
  localparam int NUM_SETS   = 7;

  // One row per weight set, columns are kw_1, kh_1, cin_1, cols_1, blocks_1
  localparam int SETS [NUM_SETS][5] = '{
    '{2, 2, 1, 1, 1}, '{0, 0, 3, 1, 1}, '{2, 2, 2, 2, 1},
    '{2, 2, 1, 1, 1}, '{0, 0, 3, 0, 1}, '{2, 2, 2, 1, 0}, '{2, 2, 1, 0, 0}
  };

  logic           i_aclk;
  logic           i_arst_n;
  logic           i_s_valid;
  logic           o_s_ready;
  logic [BW-1:0]  i_s_data;
  logic           i_s_last;
  logic           o_m_valid;
  logic           i_m_ready;
  logic [BW-1:0]  o_m_data;
  logic           o_m_last;
  wrot_pkg::tag_t o_m_user;

  integer         seed;
  int             errors;
  int             checks;
  int             tests;
  int             exp_sets;
  int             hold_hdr;     // Input index of a header that must wait for a bank
  int             hdr_stalls;
  logic           bp_en;        // Random output back-pressure
  logic [BW-1:0]  in_data [$];
  logic           in_last [$];
  logic [BW-1:0]  exp_data [$];
  wrot_pkg::tag_t exp_tag [$];
  logic           exp_last [$];

  axis_weight_rotator axis_weight_rotator_i (
    .i_aclk    (i_aclk),
    .i_arst_n  (i_arst_n),
    .i_s_valid (i_s_valid),
    .o_s_ready (o_s_ready),
    .i_s_data  (i_s_data),
    .i_s_last  (i_s_last),
    .o_m_valid (o_m_valid),
    .i_m_ready (i_m_ready),
    .o_m_data  (o_m_data),
    .o_m_last  (o_m_last),
    .o_m_user  (o_m_user)
  );

  bind axis_weight_rotator tb_wrot_chk chk_i (
    .i_aclk    (i_aclk),
    .i_arst_n  (i_arst_n),
    .i_m_valid (o_m_valid),
    .i_m_ready (i_m_ready),
    .i_m_data  (o_m_data),
    .i_m_last  (o_m_last),
    .i_m_user  (o_m_user)
  );

  initial begin
    i_aclk = 1'b0;
    forever #(CLK_PERIOD / 2) i_aclk = ~i_aclk;
  end

  function automatic logic [BW-1:0] random_word();
    logic [63:0] w;
    w = {$random(seed), $random(seed)};
    return w[BW-1:0];
  endfunction

  function automatic int out_beats(input int s);
    int n_cfg;
    n_cfg = (SETS[s][1] == 0) ? `WROT_CFG_BEATS_1X1 : `WROT_CFG_BEATS_3X3;
    return n_cfg + (SETS[s][1] + 1) * (SETS[s][2] + 1) * (SETS[s][3] + 1) * (SETS[s][4] + 1);
  endfunction

  // Queues the input beats of one set and its expanded output stream
  task automatic add_set(input int s);
    wrot_pkg::hdr_t hdr;
    wrot_pkg::tag_t tag;
    logic [BW-1:0]  hdr_word;
    logic [BW-1:0]  words [$];
    int             n_cfg;
    int             n_body;
    logic [BW-1:0]  w;
    hdr.kw_1     = wrot_pkg::KW_W'(SETS[s][0]);
    hdr.kh_1     = wrot_pkg::KH_W'(SETS[s][1]);
    hdr.cin_1    = wrot_pkg::CIN_W'(SETS[s][2]);
    hdr.cols_1   = wrot_pkg::COLS_W'(SETS[s][3]);
    hdr.blocks_1 = wrot_pkg::BLOCKS_W'(SETS[s][4]);
    hdr_word = random_word();   // Bits above the header are don't-care
    hdr_word[$bits(wrot_pkg::hdr_t)-1:0] = hdr;
    in_data.push_back(hdr_word);
    in_last.push_back(1'b0);
    n_cfg  = (SETS[s][1] == 0) ? `WROT_CFG_BEATS_1X1 : `WROT_CFG_BEATS_3X3;
    n_body = n_cfg + (SETS[s][1] + 1) * (SETS[s][2] + 1);
    tag = '0;
    tag.kw_1   = hdr.kw_1;
    tag.is_1x1 = (SETS[s][0] == 0);
    for (int i = 0; i < n_body; i++) begin
      w = random_word();
      words.push_back(w);
      in_data.push_back(w);
      in_last.push_back(i == n_body - 1);
    end
    tag.is_config = 1'b1;
    for (int i = 0; i < n_cfg; i++) begin
      exp_data.push_back(words[i]);
      exp_tag.push_back(tag);
      exp_last.push_back(1'b0);
    end
    tag.is_config = 1'b0;
    for (int b = 0; b <= SETS[s][4]; b++) begin
      for (int c = 0; c <= SETS[s][3]; c++) begin
        for (int ci = 0; ci <= SETS[s][2]; ci++) begin
          for (int k = 0; k <= SETS[s][1]; k++) begin
            tag.is_acc_last     = (k == SETS[s][1]) && (ci == SETS[s][2]);
            tag.is_top_block    = (b == 0);
            tag.is_bottom_block = (b == SETS[s][4]);
            tag.is_cols_1_k2    = ((SETS[s][3] - c) == (SETS[s][0] / 2));
            exp_data.push_back(words[n_cfg + ci * (SETS[s][1] + 1) + k]);
            exp_tag.push_back(tag);
            exp_last.push_back(tag.is_acc_last && (c == SETS[s][3]) && (b == SETS[s][4]));
          end
        end
      end
    end
    exp_sets++;
  endtask

  task automatic check_word(input logic [BW-1:0] got, input logic [BW-1:0] want,
                            input int beat);
    checks++;
    if (got !== want) begin
      errors++;
      $display("** Error at %0t: beat %0d data %h, expected %h", $time, beat, got, want);
    end
  endtask

  task automatic check_tag(input wrot_pkg::tag_t got, input logic got_last,
                           input wrot_pkg::tag_t want, input logic want_last, input int beat);
    checks++;
    if (got !== want || got_last !== want_last) begin
      errors++;
      $display("** Error at %0t: beat %0d tag %b last %b, expected tag %b last %b",
               $time, beat, got, got_last, want, want_last);
    end
  endtask

  task automatic drive_input();
    int   idx;
    logic taken;
    idx = 0;
    while (idx < in_data.size()) begin
      i_s_valid <= 1'b1;
      i_s_data  <= in_data[idx];
      i_s_last  <= in_last[idx];
      @(negedge i_aclk);
      taken = o_s_ready;   // Ready is stable mid-cycle, the transfer happens at the next edge
      @(posedge i_aclk);
      if (taken) begin
        idx++;
      end else if (idx == hold_hdr) begin
        hdr_stalls++;
      end
    end
    i_s_valid <= 1'b0;
    i_s_last  <= 1'b0;
  endtask

  task automatic collect_output();
    int n;
    int lasts;
    n     = 0;
    lasts = 0;
    while (exp_data.size() > 0) begin
      @(negedge i_aclk);
      if (o_m_valid && i_m_ready) begin
        check_word(o_m_data, exp_data.pop_front(), n);
        check_tag(o_m_user, o_m_last, exp_tag.pop_front(), exp_last.pop_front(), n);
        if (o_m_last) lasts++;
        n++;
      end
      @(posedge i_aclk);
      i_m_ready <= bp_en ? (($random(seed) % 3) != 0) : 1'b1;
    end
    i_m_ready <= 1'b0;
    if (lasts != exp_sets) begin
      errors++;
      $display("Wrong number of last flags, %0d seen for %0d sets", lasts, exp_sets);
    end
    repeat (4) @(posedge i_aclk);
    @(negedge i_aclk);
    if (o_m_valid) begin
      errors++;
      $display("Output still valid after the expected beats were all received");
    end
    @(posedge i_aclk);
  endtask

  task automatic run_sets();
    fork
      drive_input();
      collect_output();
    join
    in_data.delete();
    in_last.delete();
    exp_sets = 0;
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests++;
    $display("Test %0d (%s) done with %0d errors", tests, name, errors - err_before);
  endtask

  task automatic test_kernel_3x3();
    int err_before;
    err_before = errors;
    add_set(0);
    run_sets();
    finish_test("3x3 kernel, 2 cols, 2 blocks", err_before);
  endtask

  task automatic test_kernel_1x1();
    int err_before;
    err_before = errors;
    add_set(1);
    run_sets();
    finish_test("1x1 kernel", err_before);
  endtask

  task automatic test_back_pressure();
    int err_before;
    err_before = errors;
    bp_en = 1'b1;
    add_set(2);
    run_sets();
    bp_en = 1'b0;
    finish_test("random back-pressure", err_before);
  endtask

  task automatic test_three_sets();
    int err_before;
    err_before = errors;
    hdr_stalls = 0;
    add_set(3);
    add_set(4);
    hold_hdr = in_data.size();   // Both banks are busy when this header arrives
    add_set(5);
    run_sets();
    if (hdr_stalls == 0) begin
      errors++;
      $display("Third header was accepted without waiting for a free bank");
    end
    hold_hdr = -1;
    finish_test("three sets back to back", err_before);
  endtask

  task automatic test_single_pass();
    int err_before;
    err_before = errors;
    add_set(6);
    run_sets();
    finish_test("one column, one block", err_before);
  endtask

  initial begin : watchdog
    int total;
    total = 0;
    for (int s = 0; s < NUM_SETS; s++) begin
      total += out_beats(s);
    end
    #(total * 4 * CLK_PERIOD + 2000);
    $display("Timeout at %0t, the expected output beats did not all arrive", $time);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    $timeformat(-9, 0, " ns", 0);
    seed       = 81;
    errors     = 0;
    checks     = 0;
    tests      = 0;
    exp_sets   = 0;
    hold_hdr   = -1;
    hdr_stalls = 0;
    bp_en      = 1'b0;
    i_arst_n   = 1'b0;
    i_s_valid  = 1'b0;
    i_s_data   = '0;
    i_s_last   = 1'b0;
    i_m_ready  = 1'b0;
    repeat (4) @(posedge i_aclk);
    i_arst_n <= 1'b1;
    @(posedge i_aclk);
    test_kernel_3x3();
    test_kernel_1x1();
    test_back_pressure();
    test_three_sets();
    test_single_pass();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
wrot_pkg.sv
wrot_header_decode.sv
wrot_bank.sv
wrot_bank_exec.sv
wrot_tag_gen.sv
axis_weight_rotator.sv
tb_wrot_chk.sv
tb_wrot.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_wrot -f build.f -o sim_wrot
./obj_dir/sim_wrot 2>&1 | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
echo "Simulation finished without failure"
